// ==== common/muscle_link_pkg.sv ====
package muscle_link_pkg;

    ////////////////////
    // data widths
    ////////////////////

    // word on the spi wire and in the tx/rx registers
    typedef logic [31:0] word_t;
    // tick half period, in ep50trig cycles
    typedef logic [15:0] half_cnt_t;
    typedef logic [15:0] gain_t;
    // motor-neuron spikes per tick window
    typedef logic [15:0] spk_cnt_t;
    // count times gain, full product width
    typedef logic [31:0] drive_t;
    typedef logic [1:0]  cfg_addr_t;

    ////////////////////
    // register map
    ////////////////////

    localparam cfg_addr_t CFG_ADDR_CTRL     = 2'd0;
    localparam cfg_addr_t CFG_ADDR_HALF_CNT = 2'd1;
    localparam cfg_addr_t CFG_ADDR_TX_WORD  = 2'd2;
    localparam cfg_addr_t CFG_ADDR_GAIN     = 2'd3;

    // reset values
    localparam half_cnt_t HALF_CNT_RST = 16'd49;
    // ieee-754 single 1.0
    localparam word_t     TX_WORD_RST  = 32'h3F80_0000;
    localparam gain_t     GAIN_RST     = 16'd1;

    ////////////////////
    // spi framing
    ////////////////////

    localparam int SPI_BITS  = 32;
    // bit counter must reach SPI_BITS itself
    localparam int SPI_CNT_W = $clog2(SPI_BITS + 1);

    typedef enum logic [1:0] {
        SPI_IDLE,
        SPI_SHIFT,
        SPI_GAP
    } spi_state_t;

endpackage

// ==== common/link_cfg_if.sv ====
`timescale 1ns/100ps

// live configuration, register bank out to its consumers
interface link_cfg_if
    import muscle_link_pkg::*;
();

    // ctrl bit 0
    logic      sim_enable;
    half_cnt_t half_cnt;
    // word sent once per tick
    word_t     tx_word;
    gain_t     gain;

    // register bank owns every field
    modport regs (output sim_enable, half_cnt, tx_word, gain);
    // tick divider
    modport tick (input sim_enable, half_cnt);
    // spi sender
    modport master (input sim_enable, tx_word);
    // spike scaling
    modport counter (input sim_enable, gain);

endinterface

// ==== src/host_cfg_regs.sv ====
`timescale 1ns/100ps

module host_cfg_regs
    import muscle_link_pkg::*;
(
    input  logic      ep50trig,
    input  logic      reset_global,
    // four-phase host write port
    input  logic      cfg_req,
    input  cfg_addr_t cfg_addr,
    input  word_t     cfg_data,
    output logic      cfg_ack,
    // live parameter values
    link_cfg_if.regs  cfg
);

    ////////////////////
    // handshake
    ////////////////////

    logic wr_en;

    // new request seen, ack still low
    assign wr_en = cfg_req & ~cfg_ack;

    // ack follows req one edge later in both directions
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cfg_ack <= 1'b0;
        end else if (wr_en) begin
            cfg_ack <= 1'b1;
        end else if (!cfg_req) begin
            cfg_ack <= 1'b0;
        end
    end

    ////////////////////
    // parameter bank
    ////////////////////

    // written on the same edge that raises ack
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            cfg.sim_enable <= 1'b0;
            cfg.half_cnt   <= HALF_CNT_RST;
            cfg.tx_word    <= TX_WORD_RST;
            cfg.gain       <= GAIN_RST;
        end else if (wr_en) begin
            case (cfg_addr)
                // only bit 0 is defined
                CFG_ADDR_CTRL:     cfg.sim_enable <= cfg_data[0];
                // low half of data only
                CFG_ADDR_HALF_CNT: cfg.half_cnt   <= half_cnt_t'(cfg_data[15:0]);
                CFG_ADDR_TX_WORD:  cfg.tx_word    <= cfg_data;
                CFG_ADDR_GAIN:     cfg.gain       <= gain_t'(cfg_data[15:0]);
                default: begin
                    // all four addresses decoded
                end
            endcase
        end
    end

endmodule

// ==== src/sim_tick_gen.sv ====
`timescale 1ns/100ps

module sim_tick_gen
    import muscle_link_pkg::*;
(
    input  logic     ep50trig,
    input  logic     reset_global,
    link_cfg_if.tick cfg,
    // one-cycle clock enable for the sim blocks
    output logic     sim_tick
);

    // one bit wider than half_cnt, holds 2*half_cnt+1
    logic [$bits(half_cnt_t):0] div_cnt;
    logic [$bits(half_cnt_t):0] tick_limit;

    // 2*half_cnt+1
    assign tick_limit = {cfg.half_cnt, 1'b1};

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            div_cnt  <= '0;
            sim_tick <= 1'b0;
        end else if (!cfg.sim_enable) begin
            // held at zero while sim stopped
            div_cnt  <= '0;
            sim_tick <= 1'b0;
        end else if (div_cnt >= tick_limit) begin
            // wrap, also catches a shrunk half period
            div_cnt  <= '0;
            sim_tick <= 1'b1;
        end else begin
            div_cnt  <= div_cnt + 1'b1;
            sim_tick <= 1'b0;
        end
    end

endmodule

// ==== src/spike_counter.sv ====
`timescale 1ns/100ps

module spike_counter
    import muscle_link_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    link_cfg_if.counter cfg,
    input  logic        sim_tick,
    // motor-neuron spike, already on ep50trig
    input  logic        spike,
    output drive_t      spike_drive
);

    logic     spike_q;
    logic     spike_rise;
    spk_cnt_t spk_cnt;

    // rising edge only, pulse width does not matter
    assign spike_rise = spike & ~spike_q;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            spike_q <= 1'b0;
        end else begin
            spike_q <= spike;
        end
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            spk_cnt     <= '0;
            spike_drive <= '0;
        end else if (!cfg.sim_enable) begin
            spk_cnt     <= '0;
            spike_drive <= '0;
        end else if (sim_tick) begin
            // close the window, an edge now opens the next one
            spike_drive <= drive_t'(spk_cnt) * drive_t'(cfg.gain);
            spk_cnt     <= spk_cnt_t'(spike_rise);
        end else if (spike_rise && (spk_cnt != '1)) begin
            // saturate at all ones
            spk_cnt <= spk_cnt + 1'b1;
        end
    end

endmodule

// ==== spi_link/spi_master.sv ====
`timescale 1ns/100ps

module spi_master
    import muscle_link_pkg::*;
#(
    // sck half period in ep50trig cycles
    parameter int CLK_DIV = 13
) (
    input  logic       ep50trig,
    input  logic       reset_global,
    link_cfg_if.master cfg,
    input  logic       sim_tick,
    output logic       sck_s,
    output logic       ssel_s,
    output logic       data_s
);

    // at least one bit even for CLK_DIV of 1
    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    spi_state_t             state;
    logic [DIV_W-1:0]       div_cnt;
    logic                   half_end;
    logic [SPI_CNT_W-1:0]   bit_cnt;
    word_t                  shreg;

    // msb first
    assign data_s   = shreg[SPI_BITS-1];
    assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));

    ////////////////////
    // frame fsm
    ////////////////////

    // frame is 32 low/high pairs, a trailing low half and a gap
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state   <= SPI_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sck_s   <= 1'b0;
            ssel_s  <= 1'b1;
            shreg   <= '0;
        end else begin
            case (state)
                SPI_IDLE: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    // tick while busy is simply dropped
                    if (sim_tick && cfg.sim_enable) begin
                        shreg  <= cfg.tx_word;
                        ssel_s <= 1'b0;
                        state  <= SPI_SHIFT;
                    end
                end
                SPI_SHIFT: begin
                    if (!half_end) begin
                        div_cnt <= div_cnt + 1'b1;
                    end else begin
                        div_cnt <= '0;
                        if (sck_s) begin
                            // falling edge moves the next bit out
                            sck_s   <= 1'b0;
                            shreg   <= {shreg[SPI_BITS-2:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                        end else if (bit_cnt == SPI_CNT_W'(SPI_BITS)) begin
                            // trailing low half done
                            ssel_s <= 1'b1;
                            state  <= SPI_GAP;
                        end else begin
                            sck_s <= 1'b1;
                        end
                    end
                end
                SPI_GAP: begin
                    // ssel high for one half period
                    if (half_end) begin
                        div_cnt <= '0;
                        state   <= SPI_IDLE;
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= SPI_IDLE;
            endcase
        end
    end

endmodule

// ==== spi_link/spi_slave.sv ====
`timescale 1ns/100ps

module spi_slave
    import muscle_link_pkg::*;
(
    input  logic  ep50trig,
    input  logic  reset_global,
    // partner board pins, asynchronous
    input  logic  sck_r,
    input  logic  ssel_r,
    input  logic  data_r,
    output word_t rx_word,
    output logic  rx_valid
);

    ////////////////////
    // synchronizers
    ////////////////////

    // [1:0] two sync flops, [2] history for edge detect
    logic [2:0]           sck_pipe;
    logic [2:0]           ssel_pipe;
    logic [1:0]           data_pipe;
    logic                 sck_rise;
    logic                 ssel_rise;
    logic [SPI_CNT_W-1:0] bit_cnt;
    word_t                shreg;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sck_pipe  <= '0;
            // ssel idles high, no false edge out of reset
            ssel_pipe <= '1;
            data_pipe <= '0;
        end else begin
            sck_pipe  <= {sck_pipe[1:0], sck_r};
            ssel_pipe <= {ssel_pipe[1:0], ssel_r};
            data_pipe <= {data_pipe[0], data_r};
        end
    end

    assign sck_rise  = sck_pipe[1] & ~sck_pipe[2];
    assign ssel_rise = ssel_pipe[1] & ~ssel_pipe[2];

    ////////////////////
    // deserializer
    ////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            bit_cnt  <= '0;
            shreg    <= '0;
            rx_word  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (ssel_pipe[1]) begin
                // frame ends, publish only a full 32-bit frame
                if (ssel_rise && (bit_cnt == SPI_CNT_W'(SPI_BITS))) begin
                    rx_word  <= shreg;
                    rx_valid <= 1'b1;
                end
                bit_cnt <= '0;
            end else if (sck_rise) begin
                // sample mid-bit, data moved on the falling edge
                shreg <= {shreg[SPI_BITS-2:0], data_pipe[1]};
                // saturating, a long frame never matches
                if (bit_cnt != '1) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== src/link_board_top.sv ====
`timescale 1ns/100ps

module link_board_top
    import muscle_link_pkg::*;
#(
    // sck half period in ep50trig cycles
    parameter int CLK_DIV = 13
) (
    input  logic      ep50trig,
    input  logic      reset_global,
    // host write port
    input  logic      cfg_req,
    input  cfg_addr_t cfg_addr,
    input  word_t     cfg_data,
    output logic      cfg_ack,
    // motor-neuron spikes and scaled drive
    input  logic      spike,
    output drive_t    spike_drive,
    output logic      sim_tick,
    // spi to the partner board
    output logic      sck_s,
    output logic      ssel_s,
    output logic      data_s,
    // spi from the partner board
    input  logic      sck_r,
    input  logic      ssel_r,
    input  logic      data_r,
    output word_t     rx_word,
    output logic      rx_valid
);

    ////////////////////
    // config bus
    ////////////////////

    link_cfg_if cfg_bus ();

    host_cfg_regs host_cfg_regs_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg_req      (cfg_req),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .cfg_ack      (cfg_ack),
        .cfg          (cfg_bus.regs)
    );

    ////////////////////
    // tick and spikes
    ////////////////////

    // shared enable for master and counter
    sim_tick_gen sim_tick_gen_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg          (cfg_bus.tick),
        .sim_tick     (sim_tick)
    );

    spike_counter spike_counter_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg          (cfg_bus.counter),
        .sim_tick     (sim_tick),
        .spike        (spike),
        .spike_drive  (spike_drive)
    );

    ////////////////////
    // spi link
    ////////////////////

    spi_master #(
        .CLK_DIV (CLK_DIV)
    ) spi_master_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg          (cfg_bus.master),
        .sim_tick     (sim_tick),
        .sck_s        (sck_s),
        .ssel_s       (ssel_s),
        .data_s       (data_s)
    );

    // partner clock domain crossed inside
    spi_slave spi_slave_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sck_r        (sck_r),
        .ssel_r       (ssel_r),
        .data_r       (data_r),
        .rx_word      (rx_word),
        .rx_valid     (rx_valid)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/100ps

// free running ep50trig and power-on reset
module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic ep50trig,
    output logic reset_global
);

    initial begin
        ep50trig = 1'b0;
        forever #(PERIOD / 2) ep50trig = ~ep50trig;
    end

    // released on a falling edge, away from the dut's sampling edge
    initial begin
        reset_global = 1'b1;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;
    end

endmodule

// ==== sim/tb_checker.sv ====
`timescale 1ns/100ps

module tb_checker
    import muscle_link_pkg::*;
(
    input  logic  ep50trig,
    input  logic  reset_global,
    input  logic  cfg_req,
    input  logic  cfg_ack,
    input  logic  sim_tick,
    input  logic  sck_s,
    input  logic  ssel_s,
    input  logic  data_s,
    input  logic  rx_valid,
    input  word_t rx_word,
    // expectations from the stimulus side
    input  logic  period_chk,
    input  int    exp_period,
    input  logic  rx_chk,
    input  word_t exp_word,
    output int    error_total
);

    int    err_cnt      = 0;
    int    test_errs    = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    // stimulus controls, captured on the rising edge
    logic  rst_q        = 1'b1;
    logic  req_q        = 1'b0;
    logic  period_chk_q = 1'b0;
    int    exp_period_q = 0;
    logic  rx_chk_q     = 1'b0;
    word_t exp_word_q   = '0;
    // tick spacing and rx bookkeeping
    int    cyc          = 0;
    int    last_tick    = 0;
    logic  have_prev    = 1'b0;
    int    tick_cnt     = 0;
    int    rx_cnt       = 0;
    // outgoing frame as seen on the wire
    logic  sck_prev     = 1'b0;
    logic  ssel_prev    = 1'b1;
    word_t tx_bits      = '0;
    int    tx_bit_cnt   = 0;

    assign error_total = err_cnt;

    ////////////////////
    // reporting
    ////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            err_cnt++;
            test_errs++;
            $display("[ERROR] %0t ns %s expected %0h actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_fail(input string what);
        err_cnt++;
        test_errs++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s, %0d mismatches", name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic final_report();
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
    endtask

    ////////////////////
    // monitors
    ////////////////////

    always @(posedge ep50trig) begin
        rst_q        <= reset_global;
        req_q        <= cfg_req;
        period_chk_q <= period_chk;
        exp_period_q <= exp_period;
        rx_chk_q     <= rx_chk;
        exp_word_q   <= exp_word;
    end

    // ack should mirror req as seen on the previous rising edge
    always @(negedge ep50trig) begin
        if (!rst_q) begin
            check_value("cfg_ack", req_q, cfg_ack);
        end
    end

    always @(negedge ep50trig) begin
        cyc++;
        // spacing between successive ticks
        if (!period_chk_q) begin
            have_prev = 1'b0;
        end else if (sim_tick) begin
            if (have_prev) begin
                check_value("sim_tick period", exp_period_q, cyc - last_tick);
            end
            last_tick = cyc;
            have_prev = 1'b1;
        end
        // each received frame belongs to one tick
        if (!rx_chk_q) begin
            tick_cnt = 0;
            rx_cnt   = 0;
        end else begin
            if (sim_tick) begin
                tick_cnt++;
            end
            if (rx_valid) begin
                rx_cnt++;
                check_value("rx_word", exp_word_q, rx_word);
                check_value("rx_valid count", tick_cnt, rx_cnt);
            end
        end
    end

    // bits on the send pins, taken at each sck rise
    always @(negedge ep50trig) begin
        if (!ssel_s) begin
            if (sck_s && !sck_prev) begin
                tx_bits = {tx_bits[SPI_BITS-2:0], data_s};
                tx_bit_cnt++;
            end
        end else if (!ssel_prev) begin
            // ssel just went high, frame closed
            if (rx_chk_q) begin
                check_value("data_s", exp_word_q, tx_bits);
                check_value("sck_s rising edges", SPI_BITS, tx_bit_cnt);
            end
            tx_bit_cnt = 0;
        end
        sck_prev  = sck_s;
        ssel_prev = ssel_s;
    end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/100ps

module tb_top
    import muscle_link_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int N_TICKS     = 4;
    localparam int TICK_HALF_A = 5;
    localparam int TICK_HALF_B = 17;
    localparam int TICK_HALF_C = 40;
    // period 160 leaves room after a 133 cycle frame
    localparam int LOOP_HALF   = 79;
    localparam int N_WORDS     = 8;
    localparam int SPIKE_HALF  = 199;
    localparam int N_WINDOWS   = 3;

    logic        ep50trig;
    logic        reset_global;
    logic        cfg_req;
    cfg_addr_t   cfg_addr;
    word_t       cfg_data;
    logic        cfg_ack;
    logic        spike;
    drive_t      spike_drive;
    logic        sim_tick;
    logic        sck_s;
    logic        ssel_s;
    logic        data_s;
    word_t       rx_word;
    logic        rx_valid;
    logic        period_chk;
    int          exp_period;
    logic        rx_chk;
    word_t       exp_word;
    int          error_total;
    logic [31:0] rng = 32'hefb9;
    int          i;
    int          j;
    int          n;
    gain_t       gain;

    tb_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (3)
    ) tb_clock_gen_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global)
    );

    // spi pins looped back onto the receive side
    link_board_top #(
        .CLK_DIV (2)
    ) link_board_top_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg_req      (cfg_req),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .cfg_ack      (cfg_ack),
        .spike        (spike),
        .spike_drive  (spike_drive),
        .sim_tick     (sim_tick),
        .sck_s        (sck_s),
        .ssel_s       (ssel_s),
        .data_s       (data_s),
        .sck_r        (sck_s),
        .ssel_r       (ssel_s),
        .data_r       (data_s),
        .rx_word      (rx_word),
        .rx_valid     (rx_valid)
    );

    tb_checker tb_checker_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg_req      (cfg_req),
        .cfg_ack      (cfg_ack),
        .sim_tick     (sim_tick),
        .sck_s        (sck_s),
        .ssel_s       (ssel_s),
        .data_s       (data_s),
        .rx_valid     (rx_valid),
        .rx_word      (rx_word),
        .period_chk   (period_chk),
        .exp_period   (exp_period),
        .rx_chk       (rx_chk),
        .exp_word     (exp_word),
        .error_total  (error_total)
    );

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // count saturates at 16 bits, then scaled by the gain
    function automatic drive_t expected_drive(input int spikes, input gain_t g);
        int unsigned cnt;
        cnt = (spikes > 65535) ? 65535 : spikes;
        return drive_t'(cnt) * drive_t'(g);
    endfunction

    // all tick periods used, settle waits and a margin
    function automatic int run_budget_cycles();
        int total;
        total = 600;
        total = total + (N_TICKS + 2) * 2 * (TICK_HALF_A + TICK_HALF_B + TICK_HALF_C + 3);
        total = total + (N_WORDS + 2) * 2 * (LOOP_HALF + 1);
        total = total + (N_WINDOWS + 3) * 2 * (SPIKE_HALF + 1);
        total = total + 4 * 200 + 2000;
        return total;
    endfunction

    // four-phase write, ack awaited in both phases
    task automatic host_write(input cfg_addr_t addr, input word_t data);
        int waited;
        waited = 0;
        @(negedge ep50trig);
        cfg_addr = addr;
        cfg_data = data;
        cfg_req  = 1'b1;
        @(negedge ep50trig);
        while (!cfg_ack && waited < 20) begin
            @(negedge ep50trig);
            waited++;
        end
        if (!cfg_ack) begin
            tb_checker_i.report_fail("cfg_ack never rose after cfg_req");
        end
        cfg_req = 1'b0;
        waited  = 0;
        @(negedge ep50trig);
        while (cfg_ack && waited < 20) begin
            @(negedge ep50trig);
            waited++;
        end
        if (cfg_ack) begin
            tb_checker_i.report_fail("cfg_ack stayed high after cfg_req fell");
        end
    endtask

    task automatic wait_tick();
        int waited;
        waited = 0;
        @(negedge ep50trig);
        while (!sim_tick && waited < 1000) begin
            @(negedge ep50trig);
            waited++;
        end
        if (!sim_tick) begin
            tb_checker_i.report_fail("no sim_tick within 1000 cycles");
        end
    endtask

    task automatic wait_rx();
        int waited;
        waited = 0;
        @(negedge ep50trig);
        while (!rx_valid && waited < 1000) begin
            @(negedge ep50trig);
            waited++;
        end
        if (!rx_valid) begin
            tb_checker_i.report_fail("no rx_valid within 1000 cycles");
        end
    endtask

    task automatic run_tick_period(input int h);
        host_write(CFG_ADDR_HALF_CNT, word_t'(h));
        exp_period = 2 * (h + 1);
        host_write(CFG_ADDR_CTRL, 32'd1);
        period_chk = 1'b1;
        repeat (N_TICKS + 1) wait_tick();
        period_chk = 1'b0;
        host_write(CFG_ADDR_CTRL, 32'd0);
        // let a frame in flight drain
        repeat (200) @(negedge ep50trig);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        cfg_req    = 1'b0;
        cfg_addr   = '0;
        cfg_data   = '0;
        spike      = 1'b0;
        period_chk = 1'b0;
        exp_period = 0;
        rx_chk     = 1'b0;
        exp_word   = '0;
        @(negedge reset_global);
        @(negedge ep50trig);

        // reset values, then silence with sim stopped
        tb_checker_i.check_value("cfg_ack", 32'd0, cfg_ack);
        tb_checker_i.check_value("sim_tick", 32'd0, sim_tick);
        tb_checker_i.check_value("rx_valid", 32'd0, rx_valid);
        tb_checker_i.check_value("sck_s", 32'd0, sck_s);
        tb_checker_i.check_value("ssel_s", 32'd1, ssel_s);
        tb_checker_i.check_value("spike_drive", 32'd0, spike_drive);
        tb_checker_i.check_value("rx_word", 32'd0, rx_word);
        repeat (500) begin
            @(negedge ep50trig);
            if (sim_tick) begin
                tb_checker_i.report_fail("sim_tick pulsed while sim_enable was low");
            end
        end
        tb_checker_i.end_test("reset_state");

        // handshake timing is watched by the checker on every write
        for (i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            host_write(cfg_addr_t'(i % 3 + 1), rng);
        end
        host_write(CFG_ADDR_CTRL, 32'd0);
        tb_checker_i.end_test("host_handshake");

        run_tick_period(TICK_HALF_A);
        run_tick_period(TICK_HALF_B);
        run_tick_period(TICK_HALF_C);
        tb_checker_i.end_test("tick_period");

        // next word goes in during the gap after each frame
        host_write(CFG_ADDR_HALF_CNT, word_t'(LOOP_HALF));
        rng      = xorshift32(rng);
        exp_word = rng;
        host_write(CFG_ADDR_TX_WORD, rng);
        rx_chk = 1'b1;
        host_write(CFG_ADDR_CTRL, 32'd1);
        for (i = 0; i < N_WORDS; i++) begin
            wait_rx();
            if (i < N_WORDS - 1) begin
                rng      = xorshift32(rng);
                exp_word = rng;
                host_write(CFG_ADDR_TX_WORD, rng);
            end
        end
        rx_chk = 1'b0;
        host_write(CFG_ADDR_CTRL, 32'd0);
        repeat (200) @(negedge ep50trig);
        tb_checker_i.end_test("spi_loopback");

        // random spike bursts, each inside one tick window
        rng  = xorshift32(rng);
        gain = rng[15:0];
        host_write(CFG_ADDR_GAIN, word_t'(gain));
        host_write(CFG_ADDR_HALF_CNT, word_t'(SPIKE_HALF));
        host_write(CFG_ADDR_CTRL, 32'd1);
        wait_tick();
        for (i = 0; i < N_WINDOWS; i++) begin
            @(negedge ep50trig);
            rng = xorshift32(rng);
            n   = rng % 40 + 1;
            for (j = 0; j < n; j++) begin
                spike = 1'b1;
                @(negedge ep50trig);
                spike = 1'b0;
                rng   = xorshift32(rng);
                repeat (1 + rng % 3) @(negedge ep50trig);
            end
            wait_tick();
            @(negedge ep50trig);
            tb_checker_i.check_value("spike_drive", expected_drive(n, gain), spike_drive);
        end
        host_write(CFG_ADDR_CTRL, 32'd0);
        @(negedge ep50trig);
        tb_checker_i.check_value("spike_drive", 32'd0, spike_drive);
        tb_checker_i.end_test("spike_drive");

        tb_checker_i.final_report();
        @(negedge ep50trig);
        if (error_total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(CLK_PERIOD * run_budget_cycles());
        $display("timeout: run did not finish within %0d cycles", run_budget_cycles());
        $display("Test failed");
        $finish;
    end

endmodule

// ==== sim.f ====
common/muscle_link_pkg.sv
common/link_cfg_if.sv
src/host_cfg_regs.sv
src/sim_tick_gen.sv
src/spike_counter.sv
spi_link/spi_master.sv
spi_link/spi_slave.sv
src/link_board_top.sv
sim/tb_clock_gen.sv
sim/tb_checker.sv
sim/tb_top.sv
